//--- common/audio_pkg.sv
// shared audio types for the PC/XT sound path
// sample, level and mix widths, boost mode encoding
// compressor knee, gain and slope constants

package audio_pkg;

    ////////////////////
    // sample types
    ////////////////////

    // signed 16-bit PCM sample
    typedef logic signed [15:0] sample_t;

    // one source after sign extension and scaling
    typedef logic signed [16:0] level_t;

    // headroom for the sum of three levels
    typedef logic signed [17:0] mix_t;

    // raw Tandy sound chip output, unsigned
    typedef logic [7:0] tandy_sample_t;

    // left-shift amount 0..3
    typedef logic [1:0] volume_t;

    // boost select, code 3 also picks the 4x curve
    typedef enum logic [1:0] {
        boost_off = 2'd0,
        boost_2x  = 2'd1,
        boost_4x  = 2'd2
    } boost_e;

    ////////////////////
    // limits and curves
    ////////////////////

    localparam sample_t sample_max = 16'sh7fff;
    localparam sample_t sample_min = 16'sh8000;

    // 2x curve, gain 2 below the knee, 1/4 slope above
    localparam logic [15:0] knee_2x      = 16'd14044;
    localparam logic [15:0] gain_2x      = 16'd2;
    localparam logic [15:0] slope_div_2x = 16'd4;
    localparam logic [15:0] knee_2x_base = 16'd28088;

    // 4x curve, gain 4 below the knee, 1/8 slope above
    localparam logic [15:0] knee_4x      = 16'd7400;
    localparam logic [15:0] gain_4x      = 16'd4;
    localparam logic [15:0] slope_div_4x = 16'd8;
    localparam logic [15:0] knee_4x_base = 16'd29600;

endpackage

//--- rtl/audio/audio_input_stage.sv
// source conditioning for the audio path
// settle filters on the FM and Tandy samples
// volume scaling of the Tandy sample and the PC speaker

`timescale 1ns/1ps

module audio_input_stage import audio_pkg::*;
(
    input  logic          clk_chipset,
    input  logic          reset,
    input  sample_t       opl_sample,
    input  tandy_sample_t tandy_sample,
    input  logic          speaker_out,
    input  volume_t       tandy_volume,
    input  volume_t       speaker_volume,
    output level_t        opl_level,
    output level_t        tandy_level,
    output level_t        speaker_level
);

    // two-deep history of the FM sample
    sample_t     opl_d0;
    sample_t     opl_d1;

    // tandy value after volume, then its history
    logic [10:0] tandy_shifted;
    logic [14:0] tandy_scaled;
    logic [14:0] tandy_d0;
    logic [14:0] tandy_d1;

    // speaker is active low
    logic [3:0]  speaker_shifted;

    assign tandy_shifted   = {3'b000, tandy_sample} << tandy_volume;
    assign speaker_shifted = {3'b000, ~speaker_out} << speaker_volume;

    ////////////////////
    // settle filters
    ////////////////////

    always_ff @(posedge clk_chipset, posedge reset)
    begin
        if (reset)
        begin
            opl_d0       <= '0;
            opl_d1       <= '0;
            opl_level    <= '0;
            tandy_scaled <= '0;
            tandy_d0     <= '0;
            tandy_d1     <= '0;
            tandy_level  <= '0;
        end
        else
        begin
            opl_d0 <= opl_sample;
            opl_d1 <= opl_d0;
            // only take a value that held for two samples
            if (opl_d0 == opl_d1)
                opl_level <= {opl_d1[15], opl_d1};

            // scale first, filter the scaled value
            tandy_scaled <= {tandy_shifted, 4'b0000};
            tandy_d0     <= tandy_scaled;
            tandy_d1     <= tandy_d0;
            if (tandy_d0 == tandy_d1)
                tandy_level <= {2'b00, tandy_d1};
        end
    end

    ////////////////////
    // speaker
    ////////////////////

    // 2048 up to 16384 while sounding
    always_ff @(posedge clk_chipset, posedge reset)
    begin
        if (reset)
            speaker_level <= '0;
        else
            speaker_level <= {2'b00, speaker_shifted, 11'd0};
    end

endmodule

//--- rtl/audio/audio_mixer.sv
// three-source audio mixer
// widened sum, then saturation to a signed 16-bit sample

`timescale 1ns/1ps

module audio_mixer import audio_pkg::*;
(
    input  logic    clk_chipset,
    input  logic    reset,
    input  level_t  opl_level,
    input  level_t  tandy_level,
    input  level_t  speaker_level,
    output sample_t mixed
);

    // raw sum, two bits wider than a sample
    mix_t sum;

    always_ff @(posedge clk_chipset, posedge reset)
    begin
        if (reset)
            sum <= '0;
        else
            sum <= mix_t'(opl_level) + mix_t'(tandy_level) + mix_t'(speaker_level);
    end

    ////////////////////
    // clamp
    ////////////////////

    always_ff @(posedge clk_chipset, posedge reset)
    begin
        if (reset)
            mixed <= '0;
        else if (sum > mix_t'(sample_max))
            mixed <= sample_max;
        else if (sum < mix_t'(sample_min))
            mixed <= sample_min;
        else
            mixed <= sample_t'(sum);
    end

endmodule

//--- rtl/audio/audio_compressor.sv
// dynamic range compressor for the mixed sample
// 2x and 4x curves, bypass when boost is off

`timescale 1ns/1ps

module audio_compressor import audio_pkg::*;
(
    input  logic    clk_chipset,
    input  logic    reset,
    input  sample_t mixed,
    input  boost_e  boost,
    output sample_t pcm_out
);

    logic [15:0] mag;
    logic [15:0] curve_2x;
    logic [15:0] curve_4x;
    logic [15:0] curve_sel;
    logic [15:0] compressed;

    ////////////////////
    // curves
    ////////////////////

    always_comb
    begin
        // 16-bit negate, -32768 maps to 0x8000
        mag = mixed[15] ? (~mixed + 16'd1) : mixed;

        // linear gain below the knee, shallow slope above
        if (mag < knee_2x)
            curve_2x = mag * gain_2x;
        else
            curve_2x = ((mag - knee_2x) / slope_div_2x) + knee_2x_base;

        if (mag < knee_4x)
            curve_4x = mag * gain_4x;
        else
            curve_4x = ((mag - knee_4x) / slope_div_4x) + knee_4x_base;

        // any other nonzero code means 4x
        if (boost == boost_2x)
            curve_sel = curve_2x;
        else
            curve_sel = curve_4x;

        // put the sign back
        compressed = mixed[15] ? (~curve_sel + 16'd1) : curve_sel;
    end

    ////////////////////
    // output register
    ////////////////////

    always_ff @(posedge clk_chipset, posedge reset)
    begin
        if (reset)
            pcm_out <= '0;
        else if (boost == boost_off)
            pcm_out <= mixed;
        else
            pcm_out <= sample_t'(compressed);
    end

endmodule

//--- rtl/audio/sigma_delta_dac.sv
// first-order sigma-delta modulator
// signed sample in, one-bit density stream out

`timescale 1ns/1ps

module sigma_delta_dac import audio_pkg::*;
(
    input  logic    clk_chipset,
    input  logic    reset,
    input  sample_t sample,
    output logic    audio_out
);

    logic [15:0] offset;
    logic [16:0] acc;

    // flip the sign bit for offset binary
    assign offset = {~sample[15], sample[14:0]};

    // carry out of the low 16 bits is the next output bit
    always_ff @(posedge clk_chipset, posedge reset)
    begin
        if (reset)
        begin
            acc       <= '0;
            audio_out <= 1'b0;
        end
        else
        begin
            acc       <= {1'b0, acc[15:0]} + {1'b0, offset};
            audio_out <= acc[16];
        end
    end

endmodule

//--- rtl/pcxt_audio.sv
// audio output path of the PC/XT core
// input stage, mixer, compressor and sigma-delta DAC in a chain

`timescale 1ns/1ps

module pcxt_audio import audio_pkg::*;
(
    input  logic          clk_chipset,
    input  logic          reset,
    input  sample_t       opl_sample,
    input  tandy_sample_t tandy_sample,
    input  logic          speaker_out,
    input  volume_t       tandy_volume,
    input  volume_t       speaker_volume,
    input  boost_e        boost,
    output sample_t       pcm_out,
    output logic          audio_out
);

    level_t  opl_level;
    level_t  tandy_level;
    level_t  speaker_level;
    sample_t mixed;

    audio_input_stage u_audio_input_stage
    (
        .clk_chipset    (clk_chipset),
        .reset          (reset),
        .opl_sample     (opl_sample),
        .tandy_sample   (tandy_sample),
        .speaker_out    (speaker_out),
        .tandy_volume   (tandy_volume),
        .speaker_volume (speaker_volume),
        .opl_level      (opl_level),
        .tandy_level    (tandy_level),
        .speaker_level  (speaker_level)
    );

    audio_mixer u_audio_mixer
    (
        .clk_chipset    (clk_chipset),
        .reset          (reset),
        .opl_level      (opl_level),
        .tandy_level    (tandy_level),
        .speaker_level  (speaker_level),
        .mixed          (mixed)
    );

    audio_compressor u_audio_compressor
    (
        .clk_chipset    (clk_chipset),
        .reset          (reset),
        .mixed          (mixed),
        .boost          (boost),
        .pcm_out        (pcm_out)
    );

    // single mono bitstream
    sigma_delta_dac u_sigma_delta_dac
    (
        .clk_chipset    (clk_chipset),
        .reset          (reset),
        .sample         (pcm_out),
        .audio_out      (audio_out)
    );

endmodule

//--- tb/tb_clock_gen.sv
// testbench clock and reset source
// 8 ns clk_chipset, reset held for two cycles

`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk_chipset,
    output logic reset
);

    initial
    begin
        clk_chipset = 1'b0;
        forever
            #4 clk_chipset = ~clk_chipset;
    end

    // release on a falling edge, away from the sampling edge
    initial
    begin
        reset = 1'b1;
        repeat (2) @(posedge clk_chipset);
        @(negedge clk_chipset);
        reset = 1'b0;
    end

endmodule

//--- tb/tb_pcxt_audio.sv
// testbench for the PC/XT audio path
// random steady mixes against a model of scaling, clamp and compression
// settle filter, reset state and sigma-delta density checks

`timescale 1ns/1ps

module tb_pcxt_audio import audio_pkg::*;
();

    logic          clk_chipset;
    logic          reset;
    sample_t       opl_sample;
    tandy_sample_t tandy_sample;
    logic          speaker_out;
    volume_t       tandy_volume;
    volume_t       speaker_volume;
    boost_e        boost;
    sample_t       pcm_out;
    logic          audio_out;

    tb_clock_gen u_tb_clock_gen
    (
        .clk_chipset    (clk_chipset),
        .reset          (reset)
    );

    pcxt_audio u_pcxt_audio
    (
        .clk_chipset    (clk_chipset),
        .reset          (reset),
        .opl_sample     (opl_sample),
        .tandy_sample   (tandy_sample),
        .speaker_out    (speaker_out),
        .tandy_volume   (tandy_volume),
        .speaker_volume (speaker_volume),
        .boost          (boost),
        .pcm_out        (pcm_out),
        .audio_out      (audio_out)
    );

    ////////////////////
    // model
    ////////////////////

    // steady pcm_out for a held set of inputs
    function automatic logic [15:0] expected_pcm(input sample_t opl, input tandy_sample_t tandy,
        input logic spk, input volume_t tvol, input volume_t svol, input boost_e bst);
        int mix;
        int sat;
        int mag;
        int curve;
        int res;
        begin
            mix = int'(opl) + int'(tandy) * (1 << tvol) * 16;
            // speaker sounds when its line is low
            if (spk == 1'b0)
                mix = mix + (2048 << svol);
            if (mix > 32767)
                sat = 32767;
            else if (mix < -32768)
                sat = -32768;
            else
                sat = mix;
            if (bst == boost_off)
                return 16'(sat);
            mag = (sat < 0) ? -sat : sat;
            if (bst == boost_2x)
            begin
                if (mag < int'(knee_2x))
                    curve = mag * int'(gain_2x);
                else
                    curve = (mag - int'(knee_2x)) / int'(slope_div_2x) + int'(knee_2x_base);
            end
            else
            begin
                if (mag < int'(knee_4x))
                    curve = mag * int'(gain_4x);
                else
                    curve = (mag - int'(knee_4x)) / int'(slope_div_4x) + int'(knee_4x_base);
            end
            // sign goes back on in 16 bits and wraps at the top
            res = (sat < 0) ? -curve : curve;
            return 16'(res);
        end
    endfunction

    ////////////////////
    // helpers
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
        input logic [31:0] exp);
        begin
            if (got !== exp)
            begin
                $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
                $display("Test FAILED");
                $fatal(1, "stopping at first error");
            end
        end
    endtask

    task automatic fail_timeout(input string what);
        begin
            $display("timeout while waiting for %s", what);
            $display("Test FAILED");
            $fatal(1, "stopping at timeout");
        end
    endtask

    task automatic tick;
        begin
            @(posedge clk_chipset);
            #1;
        end
    endtask

    task automatic wait_reset_release;
        int cycles;
        begin
            cycles = 0;
            do
            begin
                @(negedge clk_chipset);
                #1;
                cycles++;
                if (cycles > 20)
                    fail_timeout("reset release");
            end
            while (reset);
        end
    endtask

    // new random inputs, then hold for the settle window and check
    task automatic steady_round(input int round, input logic rand_boost,
        output logic [15:0] exp);
        logic [1:0] bsel;
        begin
            opl_sample     = 16'($urandom);
            tandy_sample   = 8'($urandom);
            speaker_out    = 1'($urandom);
            tandy_volume   = 2'($urandom);
            speaker_volume = 2'($urandom);
            bsel           = 2'($urandom);
            boost          = rand_boost ? boost_e'(bsel) : boost_off;
            // force both clamp limits now and then
            if (round % 20 == 0)
            begin
                opl_sample   = 16'sh8000;
                tandy_sample = 8'd0;
                speaker_out  = 1'b1;
            end
            else if (round % 20 == 10)
            begin
                opl_sample  = 16'sh7fff;
                speaker_out = 1'b0;
            end
            exp = expected_pcm(opl_sample, tandy_sample, speaker_out, tandy_volume,
                speaker_volume, boost);
            for (int i = 0; i < 16; i++)
                tick();
            check_value("pcm_out", {16'h0000, pcm_out}, {16'h0000, exp});
        end
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial
    begin
        logic [15:0] exp;
        logic [15:0] offset;
        logic [16:0] acc_model;
        logic        exp_bit;
        logic [15:0] toggle_a;
        logic [15:0] toggle_b;
        int          ones;
        int          exp_ones;
        int          near;

        opl_sample     = '0;
        tandy_sample   = '0;
        speaker_out    = 1'b1;
        tandy_volume   = '0;
        speaker_volume = '0;
        boost          = boost_off;
        void'($urandom(32'h1583));

        // reset state, then the DAC follows its accumulator
        wait_reset_release();
        check_value("pcm_out", {16'h0000, pcm_out}, 32'h0);
        check_value("audio_out", {31'd0, audio_out}, 32'h0);
        exp       = expected_pcm(opl_sample, tandy_sample, speaker_out, tandy_volume,
            speaker_volume, boost);
        offset    = exp ^ 16'h8000;
        acc_model = '0;
        for (int i = 0; i < 8; i++)
        begin
            exp_bit   = acc_model[16];
            acc_model = {1'b0, acc_model[15:0]} + {1'b0, offset};
            tick();
            check_value("pcm_out", {16'h0000, pcm_out}, {16'h0000, exp});
            check_value("audio_out", {31'd0, audio_out}, {31'd0, exp_bit});
        end

        // plain mixes with boost off
        for (int r = 0; r < 200; r++)
            steady_round(r, 1'b0, exp);

        // all boost codes
        for (int r = 0; r < 200; r++)
            steady_round(r, 1'b1, exp);

        // fm input changing every clock must never be taken
        steady_round(1, 1'b1, exp);
        toggle_a = 16'($urandom);
        toggle_b = 16'($urandom);
        if (toggle_a == toggle_b)
            toggle_b = ~toggle_a;
        for (int i = 0; i < 20; i++)
        begin
            opl_sample = (i % 2 == 0) ? toggle_a : toggle_b;
            tick();
            check_value("pcm_out", {16'h0000, pcm_out}, {16'h0000, exp});
        end

        // ones density over 4096 clocks
        for (int r = 0; r < 20; r++)
        begin
            steady_round(r + 1, 1'b1, exp);
            offset   = exp ^ 16'h8000;
            exp_ones = int'(offset) / 16;
            ones     = 0;
            for (int i = 0; i < 4096; i++)
            begin
                tick();
                if (audio_out)
                    ones++;
            end
            // count may be off by two at most
            near = ((ones - exp_ones) >= -2 && (ones - exp_ones) <= 2) ? ones : exp_ones;
            check_value("audio_out ones", 32'(ones), 32'(near));
        end

        $display("Test OK");
        $finish;
    end

endmodule

//--- src.f
common/audio_pkg.sv
rtl/audio/audio_input_stage.sv
rtl/audio/audio_mixer.sv
rtl/audio/audio_compressor.sv
rtl/audio/sigma_delta_dac.sv
rtl/pcxt_audio.sv
tb/tb_clock_gen.sv
tb/tb_pcxt_audio.sv

//--- Makefile
TOP = tb_pcxt_audio

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module pcxt_audio
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
